//--- hdl/ghash_pkg.sv
`default_nettype none

package ghash_pkg;

    // Width of one GHASH block.
    // The field arithmetic is only defined for 128.
    localparam int NB_BLOCK = 128;

    // Blocks absorbed per beat.
    localparam int N_BLOCKS = 2;

    // One element of GF(2^128), bit 127 is the x^0 coefficient.
    typedef logic [NB_BLOCK-1:0] block_t;

    // Subkey powers for the two-block fold.
    typedef struct packed
    {
        block_t h1;
        block_t h2;
    } key_powers_t;

    // One input beat.
    // x_hi is the earlier block of the pair.
    // skip[0] drops x_lo, skip[1] drops x_hi.
    typedef struct packed
    {
        block_t                x_hi;
        block_t                x_lo;
        logic [N_BLOCKS-1:0]   skip;
    } data_beat_t;

    // Key table sequence.
    typedef enum logic [1:0]
    {
        KEY_EMPTY    = 2'd0,
        KEY_SQUARING = 2'd1,
        KEY_READY    = 2'd2
    } key_state_e;

endpackage

`default_nettype wire

//--- hdl/gf128_mult.sv
`timescale 1ns/1ps
`default_nettype none

module gf128_mult
    import ghash_pkg::*;
(
    input  wire block_t i_a,
    input  wire block_t i_b,
    output block_t      o_product
);

    // Reduction constant for x^128 + x^7 + x^2 + x + 1.
    // In GCM bit order this is 11100001 followed by zeros.
    localparam block_t R_POLY = {8'he1, {(NB_BLOCK-8){1'b0}}};

    block_t partial;
    block_t v_power;

    // One step of multiplication by x.
    // A right shift in GCM bit order, the carry out of bit 0 folds back in.
    function automatic block_t mult_by_x(input block_t v);
        block_t shifted;
        shifted = v >> 1;
        if (v[0])
        begin
            shifted = shifted ^ R_POLY;
        end
        return shifted;
    endfunction

    // Shift and add over the bits of i_a.
    // Bit 127 of i_a weights i_b itself, bit 0 weights i_b * x^127.
    always_comb
    begin
        partial = '0;
        v_power = i_b;
        for (int i = 0; i < NB_BLOCK; i++)
        begin
            if (i_a[NB_BLOCK-1-i])
            begin
                partial = partial ^ v_power;
            end
            v_power = mult_by_x(v_power);
        end
    end

    assign o_product = partial;

endmodule

`default_nettype wire

//--- hdl/h_key_power_table.sv
`timescale 1ns/1ps
`default_nettype none

module h_key_power_table
    import ghash_pkg::*;
(
    input  wire         tb_i_clock,
    input  wire         i_reset,
    input  wire         i_key_load,
    input  wire block_t i_hash_key,
    output key_powers_t o_key_powers,
    output logic        o_key_ready
);

    key_state_e state;
    block_t     h1_reg;
    block_t     h2_reg;
    block_t     h_square;

    // Squares the stored subkey.
    gf128_mult u_square
    (
        .i_a        ( h1_reg   ),
        .i_b        ( h1_reg   ),
        .o_product  ( h_square )
    );

    // A load restarts the sequence from any state.
    always_ff @(posedge tb_i_clock)
    begin
        if (i_reset)
        begin
            state <= KEY_EMPTY;
        end
        else if (i_key_load)
        begin
            state <= KEY_SQUARING;
        end
        else if (state == KEY_SQUARING)
        begin
            state <= KEY_READY;
        end
    end

    // H on the load edge, H^2 on the edge after.
    always_ff @(posedge tb_i_clock)
    begin
        if (i_key_load)
        begin
            h1_reg <= i_hash_key;
        end
        if ((state == KEY_SQUARING) && !i_key_load)
        begin
            h2_reg <= h_square;
        end
    end

    assign o_key_powers.h1 = h1_reg;
    assign o_key_powers.h2 = h2_reg;

    // Both powers are valid only here.
    assign o_key_ready = (state == KEY_READY);

endmodule

`default_nettype wire

//--- hdl/ghash_n_blocks.sv
`timescale 1ns/1ps
`default_nettype none

module ghash_n_blocks
    import ghash_pkg::*;
(
    input  wire              tb_i_clock,
    input  wire              i_reset,
    input  wire              i_valid,
    input  wire              i_sop,
    input  wire data_beat_t  i_beat,
    input  wire key_powers_t i_key_powers,
    input  wire              i_key_ready,
    output block_t           o_data_y,
    output logic             o_valid
);

    // Skip codes, bit 1 for x_hi and bit 0 for x_lo.
    localparam logic [N_BLOCKS-1:0] SKIP_NONE = 2'b00;
    localparam logic [N_BLOCKS-1:0] SKIP_LO   = 2'b01;
    localparam logic [N_BLOCKS-1:0] SKIP_HI   = 2'b10;
    localparam logic [N_BLOCKS-1:0] SKIP_BOTH = 2'b11;

    logic   beat_accept;
    block_t y_reg;
    block_t y_feedback;
    block_t hi_operand;
    block_t hi_power;
    block_t lo_operand;
    block_t lo_power;
    block_t hi_product;
    block_t lo_product;
    logic   use_products;
    block_t y_next;

    // Beats are ignored until both key powers are in place.
    assign beat_accept = i_valid && i_key_ready;

    // Start of packet folds into a cleared hash.
    assign y_feedback = i_sop ? '0 : y_reg;

    // Two-block rule by default.
    // Y_new = ((Y ^ x_hi) * H^2) ^ (x_lo * H).
    always_comb
    begin
        hi_operand   = y_feedback ^ i_beat.x_hi;
        hi_power     = i_key_powers.h2;
        lo_operand   = i_beat.x_lo;
        lo_power     = i_key_powers.h1;
        use_products = 1'b1;
        case (i_beat.skip)
            SKIP_NONE:
            begin
                use_products = 1'b1;
            end
            SKIP_LO:
            begin
                // Single block, x_hi only.
                hi_power   = i_key_powers.h1;
                lo_operand = '0;
            end
            SKIP_HI:
            begin
                // Single block, x_lo only.
                hi_operand = y_feedback ^ i_beat.x_lo;
                hi_power   = i_key_powers.h1;
                lo_operand = '0;
            end
            SKIP_BOTH:
            begin
                // Nothing to fold, the hash passes through.
                lo_operand   = '0;
                use_products = 1'b0;
            end
            default:
            begin
                use_products = 1'b1;
            end
        endcase
    end

    gf128_mult u_mult_hi
    (
        .i_a        ( hi_operand ),
        .i_b        ( hi_power   ),
        .o_product  ( hi_product )
    );

    gf128_mult u_mult_lo
    (
        .i_a        ( lo_operand ),
        .i_b        ( lo_power   ),
        .o_product  ( lo_product )
    );

    assign y_next = use_products ? (hi_product ^ lo_product) : y_feedback;

    // Accumulator and one-cycle valid pulse.
    always_ff @(posedge tb_i_clock)
    begin
        if (i_reset)
        begin
            y_reg   <= '0;
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= beat_accept;
            if (beat_accept)
            begin
                y_reg <= y_next;
            end
        end
    end

    assign o_data_y = y_reg;

endmodule

`default_nettype wire

//--- hdl/ghash_top.sv
`timescale 1ns/1ps
`default_nettype none

module ghash_top
    import ghash_pkg::*;
(
    input  wire             tb_i_clock,
    input  wire             i_reset,
    input  wire             i_key_load,
    input  wire block_t     i_hash_key,
    input  wire             i_valid,
    input  wire data_beat_t i_beat,
    input  wire             i_sop,
    output logic            o_key_ready,
    output logic            o_valid,
    output block_t          o_data_y
);

    // H and H^2 from the key table to the accumulator.
    key_powers_t key_powers;

    h_key_power_table u_h_key_power_table
    (
        .tb_i_clock     ( tb_i_clock  ),
        .i_reset        ( i_reset     ),
        .i_key_load     ( i_key_load  ),
        .i_hash_key     ( i_hash_key  ),
        .o_key_powers   ( key_powers  ),
        .o_key_ready    ( o_key_ready )
    );

    // The ready level also gates beat acceptance.
    ghash_n_blocks u_ghash_n_blocks
    (
        .tb_i_clock     ( tb_i_clock  ),
        .i_reset        ( i_reset     ),
        .i_valid        ( i_valid     ),
        .i_sop          ( i_sop       ),
        .i_beat         ( i_beat      ),
        .i_key_powers   ( key_powers  ),
        .i_key_ready    ( o_key_ready ),
        .o_data_y       ( o_data_y    ),
        .o_valid        ( o_valid     )
    );

endmodule

`default_nettype wire

//--- verification/ghash_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module ghash_monitor
    import ghash_pkg::*;
#(
    parameter int NAME_W = 128
)
(
    input  wire              tb_i_clock,
    input  wire              i_reset,
    input  wire              i_valid,
    input  wire block_t      i_data_y,
    input  wire              i_exp_push,
    input  wire block_t      i_exp_y,
    input  wire [NAME_W-1:0] i_exp_name,
    input  wire              i_done,
    output int               o_error_count,
    output int               o_checked_count
);

    // Expected Y and test name per driven beat.
    block_t            exp_q[$];
    logic [NAME_W-1:0] name_q[$];

    block_t            exp_y;
    logic [NAME_W-1:0] exp_name;
    logic              done_seen;

    initial
    begin
        o_error_count   = 0;
        o_checked_count = 0;
        done_seen       = 1'b0;
    end

    always @(posedge tb_i_clock)
    begin
        if (!i_reset)
        begin
            if (i_exp_push)
            begin
                exp_q.push_back(i_exp_y);
                name_q.push_back(i_exp_name);
            end
            if (i_valid)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("An o_valid pulse arrived with no beat waiting, Y = %h", i_data_y);
                    o_error_count = o_error_count + 1;
                end
                else
                begin
                    exp_y    = exp_q.pop_front();
                    exp_name = name_q.pop_front();
                    o_checked_count = o_checked_count + 1;
                    if (i_data_y !== exp_y)
                    begin
                        $display("[ERROR] %0s: expected %h, actual %h",
                                 exp_name, exp_y, i_data_y);
                        o_error_count = o_error_count + 1;
                    end
                end
            end
        end
        // Anything still queued never got its o_valid.
        if (i_done && !done_seen)
        begin
            done_seen = 1'b1;
            if (exp_q.size() != 0)
            begin
                $display("%0d expected results were never produced by the DUT",
                         exp_q.size());
                o_error_count = o_error_count + exp_q.size();
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/ghash_chk.sv
`timescale 1ns/1ps
`default_nettype none

module ghash_chk
(
    input wire tb_i_clock,
    input wire i_reset,
    input wire i_valid,
    input wire i_key_load,
    input wire i_key_ready,
    input wire i_out_valid
);

    // One output pulse per accepted beat, one cycle later.
    a_valid_follows_beat: assert property (@(posedge tb_i_clock) disable iff (i_reset)
        (i_valid && i_key_ready) |=> i_out_valid)
        else $error("o_valid missing one cycle after an accepted beat");

    a_no_spurious_valid: assert property (@(posedge tb_i_clock) disable iff (i_reset)
        !(i_valid && i_key_ready) |=> !i_out_valid)
        else $error("o_valid pulsed without an accepted beat");

    a_reset_clears: assert property (@(posedge tb_i_clock)
        i_reset |=> (!i_out_valid && !i_key_ready))
        else $error("o_valid or o_key_ready high during reset");

    // Low for the squaring cycle, then ready.
    a_key_ready_timing: assert property (@(posedge tb_i_clock) disable iff (i_reset)
        (i_key_load ##1 !i_key_load) |-> (!i_key_ready ##1 i_key_ready))
        else $error("o_key_ready did not rise two cycles after a key load");

endmodule

`default_nettype wire

//--- verification/tb_ghash_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ghash_top
    import ghash_pkg::*;
();

    localparam int    NAME_W    = 128;
    localparam string DATA_FILE = "verification/ghash_testdata.txt";

    logic              tb_i_clock;
    logic              i_reset;
    logic              i_key_load;
    block_t            i_hash_key;
    logic              i_valid;
    data_beat_t        i_beat;
    logic              i_sop;
    wire               o_key_ready;
    wire               o_valid;
    block_t            o_data_y;

    logic              exp_push;
    block_t            exp_y;
    logic [NAME_W-1:0] exp_name;
    logic              run_done;
    int                error_count;
    int                checked_count;
    int                record_count;
    int                parse_errors;
    logic              counted;

    ghash_top u_ghash_top
    (
        .tb_i_clock   ( tb_i_clock  ),
        .i_reset      ( i_reset     ),
        .i_key_load   ( i_key_load  ),
        .i_hash_key   ( i_hash_key  ),
        .i_valid      ( i_valid     ),
        .i_beat       ( i_beat      ),
        .i_sop        ( i_sop       ),
        .o_key_ready  ( o_key_ready ),
        .o_valid      ( o_valid     ),
        .o_data_y     ( o_data_y    )
    );

    ghash_monitor #(.NAME_W(NAME_W)) u_ghash_monitor
    (
        .tb_i_clock      ( tb_i_clock    ),
        .i_reset         ( i_reset       ),
        .i_valid         ( o_valid       ),
        .i_data_y        ( o_data_y      ),
        .i_exp_push      ( exp_push      ),
        .i_exp_y         ( exp_y         ),
        .i_exp_name      ( exp_name      ),
        .i_done          ( run_done      ),
        .o_error_count   ( error_count   ),
        .o_checked_count ( checked_count )
    );

    bind ghash_top ghash_chk u_ghash_chk
    (
        .tb_i_clock  ( tb_i_clock  ),
        .i_reset     ( i_reset     ),
        .i_valid     ( i_valid     ),
        .i_key_load  ( i_key_load  ),
        .i_key_ready ( o_key_ready ),
        .i_out_valid ( o_valid     )
    );

    always #20 tb_i_clock = ~tb_i_clock;

    task clear_strobes();
        i_key_load <= 1'b0;
        i_valid    <= 1'b0;
        i_sop      <= 1'b0;
        exp_push   <= 1'b0;
    endtask

    // Optionally offers a beat while the key is still squaring.
    task load_key(input block_t h, input logic offer_beat);
        @(posedge tb_i_clock);
        clear_strobes();
        i_key_load <= 1'b1;
        i_hash_key <= h;
        @(posedge tb_i_clock);
        clear_strobes();
        if (offer_beat)
        begin
            i_valid     <= 1'b1;
            i_sop       <= 1'b1;
            i_beat.x_hi <= '1;
            i_beat.x_lo <= '1;
            i_beat.skip <= '0;
        end
        @(posedge tb_i_clock);
        clear_strobes();
        while (!o_key_ready)
        begin
            @(posedge tb_i_clock);
        end
    endtask

    task drive_beat(input logic [NAME_W-1:0] name, input logic sop, input logic [1:0] skip,
                    input block_t x_hi, input block_t x_lo, input block_t y);
        @(posedge tb_i_clock);
        clear_strobes();
        i_valid     <= 1'b1;
        i_sop       <= sop;
        i_beat.x_hi <= x_hi;
        i_beat.x_lo <= x_lo;
        i_beat.skip <= skip;
        exp_push    <= 1'b1;
        exp_y       <= y;
        exp_name    <= name;
    endtask

    // Lets the last result drain before reset goes high.
    task apply_reset();
        @(posedge tb_i_clock);
        clear_strobes();
        repeat (3) @(posedge tb_i_clock);
        // A beat held through reset must not raise o_valid.
        i_reset <= 1'b1;
        i_valid <= 1'b1;
        repeat (8) @(posedge tb_i_clock);
        i_reset <= 1'b0;
        i_valid <= 1'b0;
    endtask

    initial
    begin
        counted = 1'b0;
        wait (counted);
        #((record_count + 20) * 160);
        $display("Watchdog expired after %0d records, the DUT stopped responding", record_count);
        $display("test failed");
        $finish;
    end

    initial
    begin
        int                fd;
        int                rc;
        int                total;
        logic [63:0]       kind;
        logic [NAME_W-1:0] name;
        logic [8*256-1:0]  line;
        block_t            key;
        block_t            x_hi;
        block_t            x_lo;
        block_t            y_val;
        logic [3:0]        sop_in;
        logic [3:0]        skip_in;

        tb_i_clock   = 1'b0;
        i_reset      = 1'b1;
        i_key_load   = 1'b0;
        i_hash_key   = '0;
        i_valid      = 1'b0;
        i_beat       = '0;
        i_sop        = 1'b0;
        exp_push     = 1'b0;
        exp_y        = '0;
        exp_name     = '0;
        run_done     = 1'b0;
        record_count = 0;
        parse_errors = 0;

        fd = $fopen(DATA_FILE, "r");
        if (fd == 0)
        begin
            $display("Cannot open the test data file %s", DATA_FILE);
            $display("test failed");
            $finish;
        end
        else
        begin
            // First pass sizes the watchdog.
            while ($fscanf(fd, "%s", kind) == 1)
            begin
                if (kind != "#")
                begin
                    record_count = record_count + 1;
                end
                rc = $fgets(line, fd);
            end
            $fclose(fd);
            counted = 1'b1;

            repeat (8) @(posedge tb_i_clock);
            i_reset <= 1'b0;

            fd = $fopen(DATA_FILE, "r");
            while ($fscanf(fd, "%s", kind) == 1)
            begin
                if (kind == "#")
                begin
                    rc = $fgets(line, fd);
                end
                else if (kind == "K" || kind == "L")
                begin
                    rc = $fscanf(fd, "%h", key);
                    load_key(key, kind == "L");
                end
                else if (kind == "B")
                begin
                    rc = $fscanf(fd, "%s %h %h %h %h %h", name, sop_in, skip_in,
                                 x_hi, x_lo, y_val);
                    if (rc != 6)
                    begin
                        $display("Malformed beat record in the test data file");
                        parse_errors = parse_errors + 1;
                    end
                    else
                    begin
                        drive_beat(name, sop_in[0], skip_in[1:0], x_hi, x_lo, y_val);
                    end
                end
                else if (kind == "R")
                begin
                    apply_reset();
                end
                else
                begin
                    $display("Unknown record type %0s in the test data file", kind);
                    parse_errors = parse_errors + 1;
                end
            end
            $fclose(fd);

            @(posedge tb_i_clock);
            clear_strobes();
            repeat (4) @(posedge tb_i_clock);
            run_done <= 1'b1;
            repeat (2) @(posedge tb_i_clock);

            total = error_count + parse_errors;
            $display("%0d beats checked, %0d errors", checked_count, total);
            if (total == 0)
            begin
                $display("test passed");
            end
            else
            begin
                $display("test failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verification/ghash_testdata.txt
# K h | L h (offers one beat before ready) | R (reset)
# B name sop skip x_hi x_lo expected_y, all hex
K 40000000000000000000000000000000
B single 1 0 f0000000000000000000000000000000 0c000000000000000000000000000000 3a000000000000000000000000000000
B chain1 0 0 12000000000000000000000000000000 00800000000000000000000000000000 0a400000000000000000000000000000
B chain2 0 0 00400000000000000000000000000000 a0000000000000000000000000000000 52800000000000000000000000000000
B skip_lo 0 1 02800000000000000000000000000000 ffff0000000000000000000000000000 28000000000000000000000000000000
B mid_sop 1 0 80000000000000000000000000000000 04000000000000000000000000000000 22000000000000000000000000000000
B skip_hi 0 2 ffff0000000000000000000000000000 06000000000000000000000000000000 12000000000000000000000000000000
B skip_both 0 3 12340000000000000000000000000000 56780000000000000000000000000000 12000000000000000000000000000000
B chain3 0 0 00000000000000000000000000000000 00000000000000000000000000000000 04800000000000000000000000000000
L 80000000000000000000000000000000
B new_key 0 0 01000000000000000000000000000000 00200000000000000000000000000000 05a00000000000000000000000000000
B new_key_sop 1 0 0123456789abcdef0123456789abcdef fedcba9876543210fedcba9876543210 ffffffffffffffffffffffffffffffff
R
K 40000000000000000000000000000000
B after_reset 0 0 f0000000000000000000000000000000 0c000000000000000000000000000000 3a000000000000000000000000000000
B reduce 1 0 00000000000000000000000000000000 00000000000000000000000000000001 e1000000000000000000000000000000

//--- compile.f
hdl/ghash_pkg.sv
hdl/gf128_mult.sv
hdl/h_key_power_table.sv
hdl/ghash_n_blocks.sv
hdl/ghash_top.sv
verification/ghash_monitor.sv
verification/ghash_chk.sv
verification/tb_ghash_top.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_ghash_top
FILELIST = compile.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
